/* phy_wr_pkg.sv */
// shared widths and types of the DDR write data path
// the top level takes its parameter defaults from DQ_WIDTH and FIFO_DEPTH
// FIFO_DEPTH must be a power of two and at least 2

package phy_wr_pkg;

	// width of one word on the DQ bus
	localparam int DQ_WIDTH = 16;

	// number of rise/fall pairs the write buffer can hold
	localparam int FIFO_DEPTH = 8;

	// one DQ word as seen on the pins in a single fr_clk cycle
	typedef logic [DQ_WIDTH-1:0] dq_word_t;

	// a rise word and a fall word, with the rise word in the upper half
	typedef logic [2*DQ_WIDTH-1:0] dq_pair_t;

	// occupancy of the pair buffer, one bit wider than a pointer so that
	// a completely full buffer can be told apart from an empty one
	typedef logic [$clog2(FIFO_DEPTH+1)-1:0] fifo_count_t;

	// the serializer is idle, or sends the rise word, or the fall word
	typedef enum logic [1:0] {
		SER_IDLE = 2'd0,
		SER_RISE = 2'd1,
		SER_FALL = 2'd2
	} ser_state_t;

endpackage

/* phy_wr_if.sv */
// carries captured write pairs from the capture stage into the pair buffer
// push is a one cycle strobe and full is a level
// a push while full is high is lost and flagged by the buffer

`timescale 1ns/1ps

interface phy_wr_if #(
	parameter int DQ_WIDTH = 16
);

	// one cycle strobe, a pair is offered on this cycle
	logic push;

	// the word that goes out first on the DQ pins
	logic [DQ_WIDTH-1:0] pair_rise;

	// the word that goes out second
	logic [DQ_WIDTH-1:0] pair_fall;

	// level from the buffer, no free slot is left
	logic full;

	// the capture stage offers pairs and can see the buffer level
	modport src (
		output push,
		output pair_rise,
		output pair_fall,
		input  full
	);

	// the buffer takes pairs and reports when it has no room
	modport snk (
		input  push,
		input  pair_rise,
		input  pair_fall,
		output full
	);

endinterface

/* wr_beat_capture.sv */
// samples the half-rate write beats of the controller on tick cycles
// the tick is a phase of fr_clk and no second clock exists
// a sampled pair is pushed one cycle after its tick, with no back-pressure

`timescale 1ns/1ps

module wr_beat_capture #(
	parameter int DQ_WIDTH = 16
) (
	input  logic                 fr_clk,
	input  logic                 arst_n,
	input  logic                 wr_valid,
	input  phy_wr_pkg::dq_word_t wr_data_rise,
	input  phy_wr_pkg::dq_word_t wr_data_fall,
	output logic                 hr_tick,
	phy_wr_if.src                wr
);

	// ****************************************
	// half-rate phase
	// ****************************************

	// toggles every fr_clk cycle, so it is high on every second cycle
	logic phase;

	// a pair was taken on the last tick and is pushed on this cycle
	logic cap_valid;

	// capture stage for the pair, this stands in for the half-rate
	// input registers of a real two-clock DDIO path
	logic [DQ_WIDTH-1:0] cap_rise;
	logic [DQ_WIDTH-1:0] cap_fall;

	// phase comes out of reset low, so the first tick is the cycle that
	// follows the first edge after reset is released
	always_ff @(posedge fr_clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			phase     <= 1'b0;
			cap_valid <= 1'b0;
		end
		else
		begin
			phase     <= ~phase;
			// the controller is only looked at on tick cycles
			cap_valid <= phase & wr_valid;
		end
	end

	// ****************************************
	// pair capture
	// ****************************************

	// data is loaded only with a valid beat on a tick
	// in between it keeps the pair that push is presenting
	always_ff @(posedge fr_clk)
	begin
		if (phase && wr_valid)
		begin
			cap_rise <= wr_data_rise;
			cap_fall <= wr_data_fall;
		end
	end

	assign hr_tick = phase;

	// the push lands on the non-tick cycle right after the sample
	assign wr.push      = cap_valid;
	assign wr.pair_rise = cap_rise;
	assign wr.pair_fall = cap_fall;

	// a push may only come out in the cycle right after a tick cycle,
	// which keeps the buffer fed at no more than the half-rate beat
	a_push_after_tick: assert property (
		@(posedge fr_clk) disable iff (!arst_n)
		wr.push |-> $past(hr_tick)
	);

endmodule

/* wr_pair_fifo.sv */
// circular buffer of rise/fall pairs between the capture stage and the serializer
// FIFO_DEPTH must be a power of two so the pointers wrap by themselves
// a push while full is lost and overflow stays set until reset

`timescale 1ns/1ps

module wr_pair_fifo #(
	parameter int DQ_WIDTH   = 16,
	parameter int FIFO_DEPTH = 8
) (
	input  logic                 fr_clk,
	input  logic                 arst_n,
	phy_wr_if.snk                wr,
	input  logic                 pop,
	output logic                 empty,
	output phy_wr_pkg::dq_pair_t rd_pair,
	output logic                 overflow
);

	// pointer width, the pointers index FIFO_DEPTH slots
	localparam int PTR_W = $clog2(FIFO_DEPTH);

	// the depth expressed in the occupancy type for compares
	localparam phy_wr_pkg::fifo_count_t DEPTH_CNT = phy_wr_pkg::fifo_count_t'(FIFO_DEPTH);

	// ****************************************
	// storage and pointers
	// ****************************************

	// pair storage
	phy_wr_pkg::dq_pair_t mem [FIFO_DEPTH];

	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;

	// number of pairs held right now
	phy_wr_pkg::fifo_count_t count;

	// a push is only written when there is room for it
	logic wr_en;

	// a pop is only honoured when there is something to read
	logic rd_en;

	assign wr_en = wr.push && !wr.full;
	assign rd_en = pop && !empty;

	// full and empty follow the occupancy directly
	assign wr.full = (count == DEPTH_CNT);
	assign empty   = (count == '0);

	// the head pair is presented all the time and valid while not empty
	assign rd_pair = mem[rd_ptr];

	// the rise word sits in the upper half of the stored pair
	always_ff @(posedge fr_clk)
	begin
		if (wr_en)
		begin
			mem[wr_ptr] <= {wr.pair_rise, wr.pair_fall};
		end
	end

	// ****************************************
	// pointer, occupancy and overflow state
	// ****************************************

	always_ff @(posedge fr_clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			wr_ptr   <= '0;
			rd_ptr   <= '0;
			count    <= '0;
			overflow <= 1'b0;
		end
		else
		begin
			if (wr_en)
			begin
				wr_ptr <= wr_ptr + 1'b1;
			end
			if (rd_en)
			begin
				rd_ptr <= rd_ptr + 1'b1;
			end

			// a push and a pop on the same cycle leave the count alone
			case ({wr_en, rd_en})
				2'b10:
				begin
					count <= count + phy_wr_pkg::fifo_count_t'(1);
				end
				2'b01:
				begin
					count <= count - phy_wr_pkg::fifo_count_t'(1);
				end
				default:
				begin
					count <= count;
				end
			endcase

			// sticky, only reset clears it
			if (wr.push && wr.full)
			begin
				overflow <= 1'b1;
			end
		end
	end

	// the serializer must look at empty before it pops
	a_no_pop_empty: assert property (
		@(posedge fr_clk) disable iff (!arst_n)
		pop |-> !empty
	);

	// occupancy can never pass the number of slots
	a_count_bound: assert property (
		@(posedge fr_clk) disable iff (!arst_n)
		count <= DEPTH_CNT
	);

endmodule

/* ddio_out_serializer.sv */
// turns buffered pairs into a double-rate word stream on fr_clk
// the rise word goes out first, then the fall word, both with dq_oe high
// hold is looked at only between pairs, so a started pair always completes

`timescale 1ns/1ps

module ddio_out_serializer #(
	parameter int DQ_WIDTH = 16
) (
	input  logic                 fr_clk,
	input  logic                 arst_n,
	input  logic                 hold,
	input  logic                 empty,
	input  phy_wr_pkg::dq_pair_t rd_pair,
	output logic                 pop,
	output phy_wr_pkg::dq_word_t dq_out,
	output logic                 dq_oe
);

	phy_wr_pkg::ser_state_t state;
	phy_wr_pkg::ser_state_t state_nxt;

	// the fall word is kept for the cycle after the rise word,
	// the rise word goes straight from the buffer into dq_out
	phy_wr_pkg::dq_word_t fall_q;

	// output mux select, high when the next word out is the fall word
	logic muxsel;

	// ****************************************
	// state machine
	// ****************************************

	// a new pair may start from idle or in the fall cycle of the last one
	// which gives a gapless stream when pairs keep coming
	assign pop = ((state == phy_wr_pkg::SER_IDLE) || (state == phy_wr_pkg::SER_FALL))
		&& !hold && !empty;

	assign muxsel = (state == phy_wr_pkg::SER_RISE);

	always_comb
	begin
		state_nxt = state;
		case (state)
			phy_wr_pkg::SER_IDLE:
			begin
				if (pop)
				begin
					state_nxt = phy_wr_pkg::SER_RISE;
				end
			end
			phy_wr_pkg::SER_RISE:
			begin
				// the fall word always follows, hold is ignored here
				state_nxt = phy_wr_pkg::SER_FALL;
			end
			phy_wr_pkg::SER_FALL:
			begin
				if (pop)
				begin
					state_nxt = phy_wr_pkg::SER_RISE;
				end
				else
				begin
					state_nxt = phy_wr_pkg::SER_IDLE;
				end
			end
			default:
			begin
				state_nxt = phy_wr_pkg::SER_IDLE;
			end
		endcase
	end

	// ****************************************
	// output register
	// ****************************************

	always_ff @(posedge fr_clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			state  <= phy_wr_pkg::SER_IDLE;
			dq_out <= '0;
			dq_oe  <= 1'b0;
		end
		else
		begin
			state <= state_nxt;
			dq_oe <= (state_nxt != phy_wr_pkg::SER_IDLE);
			// rise word on the cycle after a pop, fall word after that,
			// and the bus rests at zero when nothing is being sent
			if (pop)
			begin
				dq_out <= rd_pair[2*DQ_WIDTH-1 -: DQ_WIDTH];
			end
			else if (muxsel)
			begin
				dq_out <= fall_q;
			end
			else
			begin
				dq_out <= '0;
			end
		end
	end

	always_ff @(posedge fr_clk)
	begin
		if (pop)
		begin
			fall_q <= rd_pair[DQ_WIDTH-1:0];
		end
	end

	// output enable must mark exactly the rise and fall cycles, which are
	// the cycle right after a pop and the cycle right after a rise word
	a_oe_matches_state: assert property (
		@(posedge fr_clk) disable iff (!arst_n)
		dq_oe == ($past(pop) || ($past(state) == phy_wr_pkg::SER_RISE))
	);

endmodule

/* phy_wr_top.sv */
// write data path of the DDR PHY on a single clock fr_clk
// hr_tick marks the half-rate beats on which the controller inputs are sampled
// hold stops the output between pairs and overflow is sticky until reset

`timescale 1ns/1ps

module phy_wr_top #(
	parameter int DQ_WIDTH   = phy_wr_pkg::DQ_WIDTH,
	parameter int FIFO_DEPTH = phy_wr_pkg::FIFO_DEPTH
) (
	input  logic                 fr_clk,
	input  logic                 arst_n,
	input  logic                 wr_valid,
	input  phy_wr_pkg::dq_word_t wr_data_rise,
	input  phy_wr_pkg::dq_word_t wr_data_fall,
	input  logic                 hold,
	output logic                 hr_tick,
	output phy_wr_pkg::dq_word_t dq_out,
	output logic                 dq_oe,
	output logic                 overflow
);

	// buffer to serializer wires
	logic                 pop;
	logic                 empty;
	phy_wr_pkg::dq_pair_t rd_pair;

	// pair pushes from the capture stage into the buffer
	phy_wr_if #(.DQ_WIDTH(DQ_WIDTH)) wr_if ();

	// ****************************************
	// datapath
	// ****************************************

	wr_beat_capture #(
		.DQ_WIDTH (DQ_WIDTH)
	) u_capture (
		.fr_clk       (fr_clk),
		.arst_n       (arst_n),
		.wr_valid     (wr_valid),
		.wr_data_rise (wr_data_rise),
		.wr_data_fall (wr_data_fall),
		.hr_tick      (hr_tick),
		.wr           (wr_if.src)
	);

	wr_pair_fifo #(
		.DQ_WIDTH   (DQ_WIDTH),
		.FIFO_DEPTH (FIFO_DEPTH)
	) u_fifo (
		.fr_clk   (fr_clk),
		.arst_n   (arst_n),
		.wr       (wr_if.snk),
		.pop      (pop),
		.empty    (empty),
		.rd_pair  (rd_pair),
		.overflow (overflow)
	);

	// pops the buffer and drives the pins at the full rate
	ddio_out_serializer #(
		.DQ_WIDTH (DQ_WIDTH)
	) u_ser (
		.fr_clk  (fr_clk),
		.arst_n  (arst_n),
		.hold    (hold),
		.empty   (empty),
		.rd_pair (rd_pair),
		.pop     (pop),
		.dq_out  (dq_out),
		.dq_oe   (dq_oe)
	);

endmodule

/* tb_phy_wr.sv */
// testbench for the DDR write data path, pairs are offered on hr_tick cycles
// expected words come from a reference model of the pair buffer
// the first mismatch or timeout stops the run

`timescale 1ns/1ps

module tb_phy_wr;

	localparam int DQ_WIDTH   = phy_wr_pkg::DQ_WIDTH;
	localparam int FIFO_DEPTH = phy_wr_pkg::FIFO_DEPTH;
	localparam int WAIT_LIMIT = 400;

	logic                 fr_clk;
	logic                 arst_n;
	logic                 wr_valid;
	phy_wr_pkg::dq_word_t wr_data_rise;
	phy_wr_pkg::dq_word_t wr_data_fall;
	logic                 hold;
	logic                 hr_tick;
	phy_wr_pkg::dq_word_t dq_out;
	logic                 dq_oe;
	logic                 overflow;

	// words in the order they must leave on dq_out
	phy_wr_pkg::dq_word_t exp_q[$];

	// pairs taken by the model since hold last went high
	int held_pairs;
	int seed;

	phy_wr_top #(
		.DQ_WIDTH   (DQ_WIDTH),
		.FIFO_DEPTH (FIFO_DEPTH)
	) dut0 (
		.fr_clk       (fr_clk),
		.arst_n       (arst_n),
		.wr_valid     (wr_valid),
		.wr_data_rise (wr_data_rise),
		.wr_data_fall (wr_data_fall),
		.hold         (hold),
		.hr_tick      (hr_tick),
		.dq_out       (dq_out),
		.dq_oe        (dq_oe),
		.overflow     (overflow)
	);

	// 4 ns period
	initial
	begin
		fr_clk = 1'b0;
		forever
		begin
			#2 fr_clk = ~fr_clk;
		end
	end

	// ****************************************
	// helpers
	// ****************************************

	// inputs change 1 ns after the rising edge, outputs are settled there too
	task automatic step();
		@(posedge fr_clk);
		#1;
	endtask

	task automatic fail_run(input string why);
		$display("%s", why);
		$display("Errors found");
		$fatal(1, "simulation stopped");
	endtask

	task automatic check_value(input string sig, input logic [31:0] exp_v,
		input logic [31:0] act_v);
		if (exp_v !== act_v)
		begin
			$display("** Error at %0t: %s expected %0h, got %0h", $time, sig, exp_v, act_v);
			$display("Errors found");
			$fatal(1, "simulation stopped");
		end
	endtask

	// a pair is lost only when the buffer already holds FIFO_DEPTH pairs,
	// which the model can only reach while hold keeps the serializer away
	function automatic void model_take_pair(input phy_wr_pkg::dq_word_t rise,
		input phy_wr_pkg::dq_word_t fall);
		if (hold && held_pairs >= FIFO_DEPTH)
		begin
			return;
		end
		if (hold)
		begin
			held_pairs++;
		end
		exp_q.push_back(rise);
		exp_q.push_back(fall);
	endfunction

	// waits for a tick cycle, presents the pair for it and drops wr_valid after
	task automatic send_random_pair();
		phy_wr_pkg::dq_word_t rise;
		phy_wr_pkg::dq_word_t fall;
		int n;
		n = 0;
		while (hr_tick !== 1'b1)
		begin
			step();
			n++;
			if (n > WAIT_LIMIT)
			begin
				fail_run("hr_tick never went high");
			end
		end
		rise = phy_wr_pkg::dq_word_t'($random(seed));
		fall = phy_wr_pkg::dq_word_t'($random(seed));
		wr_valid     = 1'b1;
		wr_data_rise = rise;
		wr_data_fall = fall;
		model_take_pair(rise, fall);
		step();
		wr_valid = 1'b0;
	endtask

	// dq_oe must stay high for n_words cycles in a row, then fall
	task automatic expect_burst(input int n_words);
		int n;
		n = 0;
		while (dq_oe !== 1'b1)
		begin
			step();
			n++;
			if (n > WAIT_LIMIT)
			begin
				fail_run("dq_oe never went high for the expected burst");
			end
		end
		repeat (n_words - 1)
		begin
			step();
			check_value("dq_oe", 32'd1, 32'(dq_oe));
		end
		step();
		check_value("dq_oe", 32'd0, 32'(dq_oe));
	endtask

	task automatic watch_idle(input int cycles);
		repeat (cycles)
		begin
			step();
			check_value("dq_oe", 32'd0, 32'(dq_oe));
		end
	endtask

	// waits until every expected word has left and the bus is quiet
	task automatic wait_drain();
		int n;
		n = 0;
		do
		begin
			step();
			n++;
			if (n > WAIT_LIMIT)
			begin
				fail_run("expected words did not come out on dq_out");
			end
		end
		while (exp_q.size() != 0 || dq_oe === 1'b1);
	endtask

	task automatic release_hold();
		hold       = 1'b0;
		held_pairs = 0;
	endtask

	task automatic apply_reset();
		arst_n   = 1'b0;
		hold     = 1'b0;
		wr_valid = 1'b0;
		repeat (16)
		begin
			step();
		end
		arst_n = 1'b1;
		exp_q.delete();
		held_pairs = 0;
	endtask

	// ****************************************
	// output compare
	// ****************************************

	// each word with dq_oe high is taken off the front of the expected queue
	initial
	begin
		phy_wr_pkg::dq_word_t exp_w;
		logic tick_exp;
		logic rst_prev;
		tick_exp = 1'b0;
		rst_prev = 1'b0;
		forever
		begin
			@(negedge fr_clk);
			// hr_tick stays low in the cycle that reset is released in,
			// then alternates with every rising edge, high first
			if (arst_n === 1'b1)
			begin
				if (rst_prev === 1'b1)
				begin
					tick_exp = ~tick_exp;
				end
				else
				begin
					tick_exp = 1'b0;
				end
				check_value("hr_tick", 32'(tick_exp), 32'(hr_tick));
			end
			rst_prev = arst_n;
			if (arst_n === 1'b1 && dq_oe === 1'b1)
			begin
				if (exp_q.size() == 0)
				begin
					fail_run("dq_oe is high but no word is expected");
				end
				exp_w = exp_q.pop_front();
				check_value("dq_out", 32'(exp_w), 32'(dq_out));
			end
		end
	end

	// ****************************************
	// stimulus
	// ****************************************

	initial
	begin
		int i;
		int r;
		int hold_left;
		seed         = 32'ha89c599d;
		hold_left    = 0;
		arst_n       = 1'b0;
		wr_valid     = 1'b0;
		wr_data_rise = '0;
		wr_data_fall = '0;
		hold         = 1'b0;
		apply_reset();
		check_value("dq_oe", 32'd0, 32'(dq_oe));
		check_value("overflow", 32'd0, 32'(overflow));
		check_value("dq_out", 32'd0, 32'(dq_out));

		// one pair gives rise then fall on two cycles
		fork
			send_random_pair();
			expect_burst(2);
		join
		wait_drain();

		// a pair on every tick keeps dq_oe high without a gap
		fork
			repeat (6) send_random_pair();
			expect_burst(12);
		join
		wait_drain();

		// nothing leaves while hold is high
		hold = 1'b1;
		fork
			repeat (3) send_random_pair();
			watch_idle(10);
		join
		release_hold();
		wait_drain();
		check_value("overflow", 32'd0, 32'(overflow));

		// four pairs more than the buffer holds, the last four are lost
		hold = 1'b1;
		fork
			repeat (FIFO_DEPTH + 4) send_random_pair();
			watch_idle(2 * FIFO_DEPTH + 12);
		join
		check_value("overflow", 32'd1, 32'(overflow));
		release_hold();
		wait_drain();
		check_value("overflow", 32'd1, 32'(overflow));

		// random gaps and hold pulses of one to three pairs
		apply_reset();
		for (i = 0; i < 80; i++)
		begin
			r = $random(seed);
			if (!hold && (r & 7) == 0)
			begin
				hold      = 1'b1;
				hold_left = 1 + ((r >> 4) & 1) + ((r >> 5) & 1);
			end
			repeat ((r >> 8) & 3)
			begin
				step();
			end
			send_random_pair();
			if (hold)
			begin
				hold_left--;
				if (hold_left == 0)
				begin
					release_hold();
				end
			end
		end
		release_hold();
		wait_drain();
		check_value("overflow", 32'd0, 32'(overflow));

		$display("No errors");
		$finish;
	end

endmodule

/* compile.f */
phy_wr_pkg.sv
phy_wr_if.sv
wr_beat_capture.sv
wr_pair_fifo.sv
ddio_out_serializer.sv
phy_wr_top.sv
tb_phy_wr.sv

/* run_sim.sh */
#!/bin/sh
# builds the write data path testbench with Verilator and runs it
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal -f compile.f \
	--top-module tb_phy_wr -o sim_phy_wr

# a failed check ends the simulator with a nonzero status,
# so the result is taken from what it prints
out=$(./obj_dir/sim_phy_wr || true)
printf '%s\n' "$out"

if printf '%s\n' "$out" | grep -qx "No errors"; then
	echo "PASS"
	exit 0
else
	echo "FAIL"
	exit 1
fi
